// File: Makefile
VERILATOR ?= verilator
FLAGS = --binary --timing --assert -j 0
TOP = neoIoTb
FILELIST = sim.f
LOG = sim.log
PASS = No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: cabOutputs.sv
`timescale 1ns/1ps
`include "neo_consts.svh"

module cabOutputs
(
	input logic mclk,
	input logic rstN,
	input logic wrEn,
	input neoBusPkg::regOp wrOp,
	input logic [`NEO_DATA_W-1:0] wrData,
	output logic [`LED_W-1:0] ledOut1,
	output logic [`LED_W-1:0] ledOut2,
	output logic [`PLAYER_OUT_W-1:0] p1Out,
	output logic [`PLAYER_OUT_W-1:0] p2Out,
	output logic counter1,
	output logic counter2,
	output logic lockout1,
	output logic lockout2,
	output logic [3:0] cabState,
	output logic [2*`PLAYER_OUT_W-1:0] pOutState
);

	localparam int CntW = $clog2(`COUNTER_PULSE) + 1;

	logic [`LED_W-1:0] ledData;
	logic [1:0] cntStart;
	neoIoPkg::cntState cntSt [2];
	logic [CntW-1:0] cntLeft [2];

	// LED, player output and lockout registers
	always_ff @(posedge mclk or negedge rstN)
	begin
		if (!rstN)
		begin
			ledData <= '0;
			ledOut1 <= '0;
			ledOut2 <= '0;
			p1Out <= '0;
			p2Out <= '0;
			lockout1 <= 1'b0;
			lockout2 <= 1'b0;
		end
		else if (wrEn)
		begin
			case (wrOp)
				neoBusPkg::opCtrl1: p1Out <= wrData[`PLAYER_OUT_W-1:0];
				neoBusPkg::opCtrl2: p2Out <= wrData[`PLAYER_OUT_W-1:0];
				neoBusPkg::opLedData: ledData <= wrData[`LED_W-1:0];
				neoBusPkg::opLedLatch:
				begin
					if (wrData[0])
						ledOut1 <= ledData;
					if (wrData[1])
						ledOut2 <= ledData;
				end
				neoBusPkg::opCabCtrl:
				begin
					lockout1 <= wrData[0];
					lockout2 <= wrData[1];
				end
				default: ;
			endcase
		end
	end

	// Counter kick bits in CABCTRL
	assign cntStart[0] = wrEn && (wrOp == neoBusPkg::opCabCtrl) && wrData[2];
	assign cntStart[1] = wrEn && (wrOp == neoBusPkg::opCabCtrl) && wrData[3];

	// One pulse machine per coin counter
	for (genvar i = 0; i < 2; i++)
	begin : gCounter
		always_ff @(posedge mclk or negedge rstN)
		begin
			if (!rstN)
			begin
				cntSt[i] <= neoIoPkg::cntIdle;
				cntLeft[i] <= '0;
			end
			else
			begin
				case (cntSt[i])
					neoIoPkg::cntIdle:
					begin
						if (cntStart[i])
						begin
							cntSt[i] <= neoIoPkg::cntPulse;
							cntLeft[i] <= CntW'(`COUNTER_PULSE - 1);
						end
					end
					neoIoPkg::cntPulse:
					begin
						// Kicks while busy are dropped
						if (cntLeft[i] == '0)
							cntSt[i] <= neoIoPkg::cntIdle;
						else
							cntLeft[i] <= cntLeft[i] - 1'b1;
					end
				endcase
			end
		end
	end

	assign counter1 = (cntSt[0] == neoIoPkg::cntPulse);
	assign counter2 = (cntSt[1] == neoIoPkg::cntPulse);

	// Readback to the decoder
	assign cabState = {counter2, counter1, lockout2, lockout1};
	assign pOutState = {p2Out, p1Out};

endmodule

// File: ioDecode.sv
`timescale 1ns/1ps
`include "neo_consts.svh"

module ioDecode
(
	input logic mclk,
	input logic rstN,
	input neoBusPkg::apbReq apbIn,
	output neoBusPkg::apbRsp apbOut,
	input neoIoPkg::joySample sample,
	input logic [3:0] cabState,                   // {counter2, counter1, lockout2, lockout1}
	input logic [2*`PLAYER_OUT_W-1:0] pOutState,  // {p2Out, p1Out}
	output logic wrEn,
	output neoBusPkg::regOp wrOp,
	output logic [`NEO_DATA_W-1:0] wrData
);

	neoBusPkg::regOp op;
	logic readOnly;
	logic badAccess;
	logic accessPhase;
	logic setupDone;
	logic [`NEO_DATA_W-1:0] rdData;

	// Address map
	always_comb
	begin
		case (apbIn.paddr)
			`REG_CTRL1: op = neoBusPkg::opCtrl1;
			`REG_CTRL2: op = neoBusPkg::opCtrl2;
			`REG_STATUSB: op = neoBusPkg::opStatusB;
			`REG_DIP: op = neoBusPkg::opDip;
			`REG_LEDDATA: op = neoBusPkg::opLedData;
			`REG_LEDLATCH: op = neoBusPkg::opLedLatch;
			`REG_CABCTRL: op = neoBusPkg::opCabCtrl;
			default: op = neoBusPkg::opNone;
		endcase
	end

	assign readOnly = (op == neoBusPkg::opStatusB) || (op == neoBusPkg::opDip);
	assign badAccess = (op == neoBusPkg::opNone) || (apbIn.pwrite && readOnly);

	// Tracks that a setup phase came just before this access
	always_ff @(posedge mclk or negedge rstN)
	begin
		if (!rstN)
			setupDone <= 1'b0;
		else
			setupDone <= apbIn.psel && !apbIn.penable;
	end

	assign accessPhase = apbIn.psel && apbIn.penable;

	// Write lands on the edge that ends the access
	assign wrEn = accessPhase && setupDone && apbIn.pwrite && !badAccess;
	assign wrOp = op;
	assign wrData = apbIn.pwdata;

	// Read mux
	always_comb
	begin
		rdData = '0;
		case (op)
			neoBusPkg::opCtrl1:
			begin
				rdData[`JOY_W-1:0] = sample.p1;
				rdData[`JOY_W +: `PLAYER_OUT_W] = pOutState[0 +: `PLAYER_OUT_W];
			end
			neoBusPkg::opCtrl2:
			begin
				rdData[`JOY_W-1:0] = sample.p2;
				rdData[`JOY_W +: `PLAYER_OUT_W] = pOutState[`PLAYER_OUT_W +: `PLAYER_OUT_W];
			end
			neoBusPkg::opStatusB:
				rdData[`STATUS_W-1:0] = sample.statusB;
			neoBusPkg::opDip:
				rdData[`DIP_W-1:0] = sample.dip;
			neoBusPkg::opCabCtrl:
				rdData[3:0] = cabState; // Lockouts and counter busy flags
			default:
				rdData = '0; // LED registers and unmapped read as zero
		endcase
	end

	assign apbOut.prdata = rdData;
	assign apbOut.pready = 1'b1; // Zero wait states
	assign apbOut.pslverr = accessPhase && badAccess;

endmodule

// File: joyPort.sv
`timescale 1ns/1ps
`include "neo_consts.svh"

module joyPort
(
	input logic mclk,
	input logic rstN,
	input logic [`JOY_W-1:0] p1In,
	input logic [`JOY_W-1:0] p2In,
	input logic [`STATUS_W-1:0] statusIn,
	input logic [`DIP_W-1:0] dipSw,
	output neoIoPkg::joySample sample
);

	neoIoPkg::joySample rawPins;
	neoIoPkg::joySample meta;    // First stage, may go metastable
	neoIoPkg::joySample stable;  // Second stage

	// Raw pins in sample order
	assign rawPins.p1 = p1In;
	assign rawPins.p2 = p2In;
	assign rawPins.statusB = statusIn;
	assign rawPins.dip = dipSw;

	// Reset to the idle high level of the pins
	always_ff @(posedge mclk or negedge rstN)
	begin
		if (!rstN)
		begin
			meta <= '1;
			stable <= '1;
		end
		else
		begin
			meta <= rawPins;
			stable <= meta;
		end
	end

	assign sample = stable; // Two edges from pin to register file

endmodule

// File: neoBusPkg.sv
`include "neo_consts.svh"

package neoBusPkg;

	// Master side of the APB link
	typedef struct packed
	{
		logic psel;
		logic penable;
		logic pwrite;
		logic [`NEO_ADDR_W-1:0] paddr;
		logic [`NEO_DATA_W-1:0] pwdata;
	} apbReq;

	// Slave side
	typedef struct packed
	{
		logic [`NEO_DATA_W-1:0] prdata;
		logic pready;
		logic pslverr;
	} apbRsp;

	// One opcode per mapped register
	typedef enum logic [2:0]
	{
		opNone,     // Unmapped address
		opCtrl1,    // P1 joypad in, P1 outputs
		opCtrl2,    // P2 joypad in, P2 outputs
		opStatusB,  // Read only
		opDip,      // Read only
		opLedData,
		opLedLatch,
		opCabCtrl   // Lockouts and coin counters
	} regOp;

endpackage

// File: neoIoChecker.sv
`timescale 1ns/1ps
`include "neo_consts.svh"

module neoIoChecker
#(
	parameter int PinW = 2*`LED_W + 2*`PLAYER_OUT_W + 4
)
(
	input logic mclk,
	input logic rstN,
	input neoBusPkg::apbRsp rsp,
	input logic accCheck,                    // Access phase ends on this edge
	input logic rdCheck,
	input logic [`NEO_DATA_W-1:0] expRdData,
	input logic expSlvErr,
	input logic [PinW-1:0] pins,             // {led1, led2, p1, p2, cnt1, cnt2, lock1, lock2}
	input logic [PinW-1:0] expPins
);

	int errCount = 0;
	int checkCount = 0;

	always @(posedge mclk)
	begin
		if (rstN)
		begin
			checkCount++;
			if (pins !== expPins)
			begin
				errCount++;
				$display("error at %0d ns: output pins %h, expected %h", $time, pins, expPins);
			end
			if (accCheck)
			begin
				checkCount++;
				if (rsp.pslverr !== expSlvErr)
				begin
					errCount++;
					$display("error at %0d ns: pslverr %b, expected %b", $time, rsp.pslverr,
						expSlvErr);
				end
			end
			if (rdCheck)
			begin
				checkCount++;
				if (rsp.prdata !== expRdData)
				begin
					errCount++;
					$display("error at %0d ns: prdata %h, expected %h", $time, rsp.prdata,
						expRdData);
				end
			end
		end
	end

endmodule

// File: neoIoPkg.sv
`include "neo_consts.svh"

package neoIoPkg;

	// Synchronized input pins, as seen by the register file
	typedef struct packed
	{
		logic [`JOY_W-1:0] p1;         // Player 1 joypad
		logic [`JOY_W-1:0] p2;         // Player 2 joypad
		logic [`STATUS_W-1:0] statusB; // Start/select, card detect
		logic [`DIP_W-1:0] dip;        // Cabinet DIP switches
	} joySample;

	// Coin counter pulse machine
	typedef enum logic
	{
		cntIdle,
		cntPulse
	} cntState;

endpackage

// File: neoIoTb.sv
`timescale 1ns/1ps
`include "neo_consts.svh"

module neoIoTb;

	localparam int PinW = 2*`LED_W + 2*`PLAYER_OUT_W + 4;
	localparam int ReadyTimeout = 16;

	logic mclk;
	logic rstN;
	neoBusPkg::apbReq apbIn;
	neoBusPkg::apbRsp apbOut;
	logic [`JOY_W-1:0] p1In, p2In;
	logic [`STATUS_W-1:0] statusIn;
	logic [`DIP_W-1:0] dipSw;
	logic [`LED_W-1:0] ledOut1, ledOut2;
	logic [`PLAYER_OUT_W-1:0] p1Out, p2Out;
	logic counter1, counter2, lockout1, lockout2;

	// Register model
	logic [`LED_W-1:0] mLedData, mLed1, mLed2;
	logic [`PLAYER_OUT_W-1:0] mP1Out, mP2Out;
	logic mLock1, mLock2;
	int cycleNum = 0;
	int cntEnd1 = 0; // First cycle with the pulse over
	int cntEnd2 = 0;

	logic accCheck, rdCheck, expSlvErr;
	logic [`NEO_DATA_W-1:0] expRdData;
	logic [PinW-1:0] expPins;
	int seed;
	int rnd;

	neoIoTop dut0 (.*);

	neoIoChecker chk0
	(
		.rsp(apbOut),
		.pins({ledOut1, ledOut2, p1Out, p2Out, counter1, counter2, lockout1, lockout2}),
		.*
	);

	always #20 mclk = ~mclk;

	always @(posedge mclk)
		cycleNum <= cycleNum + 1;

	assign expPins = {mLed1, mLed2, mP1Out, mP2Out, cycleNum < cntEnd1, cycleNum < cntEnd2,
		mLock1, mLock2};

	function automatic logic expectError(input logic [`NEO_ADDR_W-1:0] addr, input logic write);
		case (addr)
			`REG_CTRL1, `REG_CTRL2, `REG_LEDDATA, `REG_LEDLATCH, `REG_CABCTRL: return 1'b0;
			`REG_STATUSB, `REG_DIP: return write; // Read only
			default: return 1'b1;
		endcase
	endfunction

	function automatic logic [`NEO_DATA_W-1:0] expectRead(input logic [`NEO_ADDR_W-1:0] addr);
		logic [`NEO_DATA_W-1:0] val;
		val = '0;
		case (addr)
			`REG_CTRL1:
			begin
				val[`JOY_W-1:0] = p1In;
				val[`JOY_W +: `PLAYER_OUT_W] = mP1Out;
			end
			`REG_CTRL2:
			begin
				val[`JOY_W-1:0] = p2In;
				val[`JOY_W +: `PLAYER_OUT_W] = mP2Out;
			end
			`REG_STATUSB: val[`STATUS_W-1:0] = statusIn;
			`REG_DIP: val[`DIP_W-1:0] = dipSw;
			`REG_CABCTRL: val[3:0] = {cycleNum < cntEnd2, cycleNum < cntEnd1, mLock2, mLock1};
			default: val = '0;
		endcase
		return val;
	endfunction

	task automatic applyWrite(input logic [`NEO_ADDR_W-1:0] addr,
		input logic [`NEO_DATA_W-1:0] data);
		case (addr)
			`REG_CTRL1: mP1Out = data[`PLAYER_OUT_W-1:0];
			`REG_CTRL2: mP2Out = data[`PLAYER_OUT_W-1:0];
			`REG_LEDDATA: mLedData = data[`LED_W-1:0];
			`REG_LEDLATCH:
			begin
				if (data[0])
					mLed1 = mLedData;
				if (data[1])
					mLed2 = mLedData;
			end
			`REG_CABCTRL:
			begin
				mLock1 = data[0];
				mLock2 = data[1];
				// Kick only lands once the last pulse is over
				if (data[2] && cntEnd1 < cycleNum)
					cntEnd1 = cycleNum + `COUNTER_PULSE;
				if (data[3] && cntEnd2 < cycleNum)
					cntEnd2 = cycleNum + `COUNTER_PULSE;
			end
			default: ;
		endcase
	endtask

	task automatic failTimeout(input string what);
		$display("Timeout at %0d ns: %s", $time, what);
		$display("Errors found");
		$finish;
	endtask

	// Called 2 ns after a rising edge
	task automatic apbAccess(input logic write, input logic [`NEO_ADDR_W-1:0] addr,
		input logic [`NEO_DATA_W-1:0] data);
		int waited;
		waited = 0;
		apbIn.psel = 1'b1;
		apbIn.penable = 1'b0;
		apbIn.pwrite = write;
		apbIn.paddr = addr;
		apbIn.pwdata = data;
		@(posedge mclk);
		#2;
		apbIn.penable = 1'b1;
		expSlvErr = expectError(addr, write);
		@(negedge mclk);
		while (apbOut.pready !== 1'b1 && waited < ReadyTimeout)
		begin
			waited++;
			@(negedge mclk);
		end
		if (apbOut.pready !== 1'b1)
			failTimeout("pready never went high in the access phase");
		else
		begin
			expRdData = expectRead(addr);
			rdCheck = !write;
			accCheck = 1'b1;
			@(posedge mclk);
			#2;
			accCheck = 1'b0;
			rdCheck = 1'b0;
			apbIn = '0;
			if (write && !expSlvErr)
				applyWrite(addr, data);
		end
	endtask

	task automatic apbWrite(input logic [`NEO_ADDR_W-1:0] addr,
		input logic [`NEO_DATA_W-1:0] data);
		apbAccess(1'b1, addr, data);
	endtask

	task automatic apbRead(input logic [`NEO_ADDR_W-1:0] addr);
		apbAccess(1'b0, addr, '0);
	endtask

	task automatic waitCountersIdle();
		int waited;
		waited = 0;
		while ((counter1 || counter2) && waited < 4*`COUNTER_PULSE)
		begin
			@(posedge mclk);
			#2;
			waited++;
		end
		if (counter1 || counter2)
			failTimeout("coin counter pulse never ended");
	endtask

	initial
	begin
		seed = 17;
		mclk = 1'b0;
		rstN = 1'b0;
		apbIn = '0;
		p1In = '1;
		p2In = '1;
		statusIn = '1;
		dipSw = '1;
		accCheck = 1'b0;
		rdCheck = 1'b0;
		expSlvErr = 1'b0;
		expRdData = '0;
		{mLedData, mLed1, mLed2, mP1Out, mP2Out, mLock1, mLock2} = '0;
		repeat (10) @(posedge mclk);
		#2;
		rstN = 1'b1;

		// Joypad, status and DIP readback
		for (int i = 0; i < 20; i++)
		begin
			rnd = $random(seed);
			p1In = rnd[`JOY_W-1:0];
			p2In = rnd[`JOY_W +: `JOY_W];
			rnd = $random(seed);
			statusIn = rnd[`STATUS_W-1:0];
			dipSw = rnd[8 +: `DIP_W];
			repeat (3) @(posedge mclk); // Past the two synchronizer stages
			#2;
			apbRead(`REG_CTRL1);
			apbRead(`REG_CTRL2);
			apbRead(`REG_STATUSB);
			apbRead(`REG_DIP);
		end

		// LED data then latch, selects 1, 2, 3
		for (int i = 0; i < 6; i++)
		begin
			rnd = $random(seed);
			apbWrite(`REG_LEDDATA, rnd[15:0]);
			apbWrite(`REG_LEDLATCH, 16'(i % 3 + 1));
			apbRead(`REG_LEDLATCH);
		end

		for (int i = 0; i < 8; i++)
		begin
			rnd = $random(seed);
			apbWrite(`REG_CTRL1, rnd[15:0]);
			apbWrite(`REG_CTRL2, rnd[31:16]);
			apbRead(`REG_CTRL1);
			apbRead(`REG_CTRL2);
		end

		// Lockouts and coin counters
		apbWrite(`REG_CABCTRL, 16'h0003);
		apbRead(`REG_CABCTRL);
		apbWrite(`REG_CABCTRL, 16'h0005);
		apbRead(`REG_CABCTRL);
		repeat (2) @(posedge mclk);
		#2;
		apbWrite(`REG_CABCTRL, 16'h0004); // Lands mid pulse
		waitCountersIdle();
		apbWrite(`REG_CABCTRL, 16'h000E);
		apbRead(`REG_CABCTRL);
		waitCountersIdle();
		apbRead(`REG_CABCTRL);

		// Error responses
		apbWrite(`REG_STATUSB, 16'hFFFF);
		apbWrite(`REG_DIP, 16'h00AA);
		apbWrite(8'h1C, 16'h01FF);
		apbWrite(8'h02, 16'h0007);
		apbRead(8'h40);
		apbRead(`REG_DIP);

		repeat (2) @(posedge mclk);
		#2;
		$display("Checks: %0d, errors: %0d", chk0.checkCount, chk0.errCount);
		if (chk0.errCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: neoIoTop.sv
`timescale 1ns/1ps
`include "neo_consts.svh"

module neoIoTop
(
	input logic mclk,
	input logic rstN,
	input neoBusPkg::apbReq apbIn,
	output neoBusPkg::apbRsp apbOut,
	input logic [`JOY_W-1:0] p1In,
	input logic [`JOY_W-1:0] p2In,
	input logic [`STATUS_W-1:0] statusIn,
	input logic [`DIP_W-1:0] dipSw,
	output logic [`LED_W-1:0] ledOut1,
	output logic [`LED_W-1:0] ledOut2,
	output logic [`PLAYER_OUT_W-1:0] p1Out,
	output logic [`PLAYER_OUT_W-1:0] p2Out,
	output logic counter1,
	output logic counter2,
	output logic lockout1,
	output logic lockout2
);

	neoIoPkg::joySample sample;
	logic wrEn;
	neoBusPkg::regOp wrOp;
	logic [`NEO_DATA_W-1:0] wrData;
	logic [3:0] cabState;
	logic [2*`PLAYER_OUT_W-1:0] pOutState;

	// Joypad, status and DIP inputs
	joyPort joy0
	(
		.mclk(mclk),
		.rstN(rstN),
		.p1In(p1In),
		.p2In(p2In),
		.statusIn(statusIn),
		.dipSw(dipSw),
		.sample(sample)
	);

	ioDecode dec0
	(
		.mclk(mclk),
		.rstN(rstN),
		.apbIn(apbIn),
		.apbOut(apbOut),
		.sample(sample),
		.cabState(cabState),
		.pOutState(pOutState),
		.wrEn(wrEn),
		.wrOp(wrOp),
		.wrData(wrData)
	);

	// LEDs, player outputs, lockouts, coin counters
	cabOutputs cab0
	(
		.mclk(mclk),
		.rstN(rstN),
		.wrEn(wrEn),
		.wrOp(wrOp),
		.wrData(wrData),
		.ledOut1(ledOut1),
		.ledOut2(ledOut2),
		.p1Out(p1Out),
		.p2Out(p2Out),
		.counter1(counter1),
		.counter2(counter2),
		.lockout1(lockout1),
		.lockout2(lockout2),
		.cabState(cabState),
		.pOutState(pOutState)
	);

endmodule

// File: neoIo_assert.sv
`timescale 1ns/1ps
`include "neo_consts.svh"

module neoIoAssert
(
	input logic mclk,
	input logic rstN,
	input neoBusPkg::apbReq apbIn,
	input neoBusPkg::apbRsp apbOut,
	input logic counter1,
	input logic counter2
);

	// Zero wait states
	readyInAccess: assert property (@(posedge mclk) disable iff (!rstN)
		apbIn.penable |-> apbOut.pready)
		else $error("pready low during an access phase");

	pulse1Len: assert property (@(posedge mclk) disable iff (!rstN)
		$rose(counter1) |-> counter1[*`COUNTER_PULSE] ##1 !counter1)
		else $error("counter1 pulse has the wrong length");

	pulse2Len: assert property (@(posedge mclk) disable iff (!rstN)
		$rose(counter2) |-> counter2[*`COUNTER_PULSE] ##1 !counter2)
		else $error("counter2 pulse has the wrong length");

	// Address held from setup into access
	addrHeld: assert property (@(posedge mclk) disable iff (!rstN)
		(apbIn.psel && !apbIn.penable) ##1 apbIn.penable |-> $stable(apbIn.paddr))
		else $error("paddr changed between setup and access");

endmodule

bind neoIoTop neoIoAssert assert0
(
	.mclk(mclk),
	.rstN(rstN),
	.apbIn(apbIn),
	.apbOut(apbOut),
	.counter1(counter1),
	.counter2(counter2)
);

// File: neo_consts.svh
`ifndef NEO_CONSTS_SVH
`define NEO_CONSTS_SVH

// APB bus geometry
`define NEO_ADDR_W 8
`define NEO_DATA_W 16

// Register byte offsets
`define REG_CTRL1    8'h00
`define REG_CTRL2    8'h04
`define REG_STATUSB  8'h08
`define REG_DIP      8'h0C
`define REG_LEDDATA  8'h10
`define REG_LEDLATCH 8'h14
`define REG_CABCTRL  8'h18

// Field widths
`define JOY_W        10 // Active low directions and buttons
`define STATUS_W     8
`define DIP_W        8
`define LED_W        9
`define PLAYER_OUT_W 3

// Coin counter pulse, in mclk cycles
`define COUNTER_PULSE 8

`endif

// File: sim.f
+incdir+.
neoBusPkg.sv
neoIoPkg.sv
joyPort.sv
ioDecode.sv
cabOutputs.sv
neoIoTop.sv
neoIoChecker.sv
neoIo_assert.sv
neoIoTb.sv
